// File: design/dz_pkg.sv
package dz_pkg;

    // panel geometry
    localparam int dz_rows = 8;
    localparam int dz_cols = 8;

    localparam int dz_num_images = 12; // 5 blobs, full panel, 6 icons

    typedef logic [$clog2(dz_rows)-1:0] dz_row_t;
    typedef logic [3:0]                 dz_img_t;
    typedef logic [dz_cols-1:0]         dz_cols_t; // 1 = led lit

    typedef struct packed {
        logic [7:0] frame_period;  // scans per image where 0 acts as 1
        logic [7:0] hot_threshold;
        logic [3:0] hysteresis;
    } dz_cfg_t;

    typedef struct packed {
        logic [dz_rows-1:0] row;  // active low row select
        dz_cols_t           colr;
        dz_cols_t           colg;
    } dz_scan_t;

    // register map
    localparam logic [1:0] dz_addr_frame_period  = 2'd0;
    localparam logic [1:0] dz_addr_hot_threshold = 2'd1;
    localparam logic [1:0] dz_addr_hysteresis    = 2'd2;

    // values after reset
    localparam logic [7:0] dz_rst_frame_period  = 8'd4;
    localparam logic [7:0] dz_rst_hot_threshold = 8'd80;
    localparam logic [3:0] dz_rst_hysteresis    = 4'd4;

endpackage

// File: design/dz_config_regs.sv
`timescale 1ns/1ps

module dz_config_regs
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_wr,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_wdata,
    output dz_cfg_t    cfg
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cfg.frame_period  <= dz_rst_frame_period;
            cfg.hot_threshold <= dz_rst_hot_threshold;
            cfg.hysteresis    <= dz_rst_hysteresis;
        end
        else if (cfg_wr)
        begin
            case (cfg_addr)
                dz_addr_frame_period:
                begin
                    cfg.frame_period <= cfg_wdata;
                end
                dz_addr_hot_threshold:
                begin
                    cfg.hot_threshold <= cfg_wdata;
                end
                dz_addr_hysteresis:
                begin
                    cfg.hysteresis <= cfg_wdata[3:0]; // upper nibble dropped
                end
                default:
                begin
                    // address 3 is unused
                end
            endcase
        end
    end

endmodule

// File: design/dz_frame_seq.sv
`timescale 1ns/1ps

module dz_frame_seq
    import dz_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    st,
    input  dz_cfg_t cfg,
    output dz_row_t row_idx,
    output dz_img_t img_idx
);

    logic [7:0] scan_cnt;  // full scans done on current image
    logic [7:0] period_m1;
    logic       row_wrap;
    logic       img_last;

    assign period_m1 = (cfg.frame_period == 8'd0) ? 8'd0 : cfg.frame_period - 8'd1;
    assign row_wrap  = (row_idx == dz_row_t'(dz_rows - 1));
    assign img_last  = (img_idx == dz_img_t'(dz_num_images - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx  <= '0;
            img_idx  <= '0;
            scan_cnt <= '0;
        end
        else if (!st)
        begin
            // held at image 0, row 0 until enabled
            row_idx  <= '0;
            img_idx  <= '0;
            scan_cnt <= '0;
        end
        else
        begin
            row_idx <= row_wrap ? dz_row_t'(0) : row_idx + dz_row_t'(1);
            if (row_wrap)
            begin
                // >= covers a period lowered mid image
                if (scan_cnt >= period_m1)
                begin
                    scan_cnt <= '0;
                    img_idx  <= img_last ? dz_img_t'(0) : img_idx + dz_img_t'(1);
                end
                else
                begin
                    scan_cnt <= scan_cnt + 8'd1;
                end
            end
        end
    end

endmodule

// File: design/dz_temp_monitor.sv
`timescale 1ns/1ps

module dz_temp_monitor
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] temp_code,
    input  dz_cfg_t    cfg,
    output logic       hot
);

    logic [7:0] hyst_ext;
    logic [7:0] fall_level;
    logic       above_rise;
    logic       below_fall;

    assign hyst_ext = {4'd0, cfg.hysteresis};

    // clamp at zero instead of wrapping
    assign fall_level = (cfg.hot_threshold > hyst_ext) ?
                        cfg.hot_threshold - hyst_ext : 8'd0;

    assign above_rise = (temp_code >= cfg.hot_threshold);
    assign below_fall = (temp_code < fall_level);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hot <= 1'b0;
        end
        else if (above_rise)
        begin
            hot <= 1'b1;
        end
        else if (below_fall)
        begin
            hot <= 1'b0;
        end
        // inside the band hot keeps its value
    end

endmodule

// File: design/dz_show.sv
`timescale 1ns/1ps

module dz_show
    import dz_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     st,
    input  dz_row_t  row_idx,
    input  dz_img_t  img_idx,
    input  logic     hot,
    output dz_scan_t scan,
    output dz_img_t  img
);

    // image rom with one column word per image and row
    function automatic dz_cols_t rom_word(input dz_img_t i, input dz_row_t r);
        dz_cols_t w;
        w = '0;
        case (i)
            4'd0:
            begin
                if (r == 3'd2 || r == 3'd5) w = 8'h18;
                if (r == 3'd3 || r == 3'd4) w = 8'h3c;
            end
            4'd1:
            begin
                if (r == 3'd2 || r == 3'd5) w = 8'h38;
                if (r == 3'd3 || r == 3'd4) w = 8'h7c;
            end
            4'd2:
            begin
                if (r == 3'd2 || r == 3'd5) w = 8'h3c;
                if (r == 3'd3 || r == 3'd4) w = 8'h7e;
            end
            4'd3:
            begin
                if (r == 3'd1 || r == 3'd6) w = 8'h3c;
                if (r >= 3'd2 && r <= 3'd5) w = 8'h7e;
            end
            4'd4:
            begin
                if (r == 3'd0 || r == 3'd7) w = 8'h3c;
                if (r == 3'd1 || r == 3'd6) w = 8'h7e;
                if (r >= 3'd2 && r <= 3'd5) w = 8'hff;
            end
            4'd5: w = 8'hff; // full panel
            4'd6:
            begin
                case (r)
                    3'd0: w = 8'hc3;
                    3'd1: w = 8'he3;
                    3'd2: w = 8'hf1;
                    3'd3: w = 8'he3;
                    3'd4: w = 8'hc7;
                    3'd5: w = 8'he7;
                    3'd6: w = 8'hf7;
                    default: w = 8'hfb;
                endcase
            end
            4'd7:
            begin
                case (r)
                    3'd0: w = 8'h00;
                    3'd1: w = 8'h01;
                    3'd2: w = 8'h81;
                    3'd3: w = 8'hc3;
                    3'd4: w = 8'h83;
                    3'd5: w = 8'hc7;
                    3'd6: w = 8'he7;
                    default: w = 8'hf3;
                endcase
            end
            4'd8:
            begin
                case (r)
                    3'd0: w = 8'h00;
                    3'd1: w = 8'h38;
                    3'd2: w = 8'h44;
                    3'd3: w = 8'h5a;
                    3'd4: w = 8'h4a;
                    3'd5: w = 8'h32;
                    3'd6: w = 8'hc4;
                    default: w = 8'h38;
                endcase
            end
            4'd9:
            begin
                case (r)
                    3'd2: w = 8'h60;
                    3'd3: w = 8'hfc;
                    3'd4: w = 8'h3f;
                    3'd5: w = 8'h3e;
                    3'd6: w = 8'h1c;
                    default: w = 8'h00;
                endcase
            end
            4'd10:
            begin
                case (r)
                    3'd2: w = 8'h18;
                    3'd3: w = 8'h3c;
                    3'd4: w = 8'h7e;
                    3'd5: w = 8'h7e;
                    3'd6: w = 8'h24;
                    default: w = 8'h00;
                endcase
            end
            4'd11:
            begin
                case (r)
                    3'd0: w = 8'he0;
                    3'd1: w = 8'h60;
                    3'd2: w = 8'he0;
                    3'd3: w = 8'h30;
                    3'd4: w = 8'h31;
                    3'd5: w = 8'h33;
                    3'd6: w = 8'h3e;
                    default: w = 8'h1c;
                endcase
            end
            default: w = '0; // indices 12..15 stay dark
        endcase
        return w;
    endfunction

    logic [dz_rows-1:0] row_sel;
    dz_cols_t           rom_colg;

    always_comb
    begin
        row_sel          = '1;
        row_sel[row_idx] = 1'b0; // one low bit per scanned row
    end

    assign rom_colg = rom_word(img_idx, row_idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan <= '{row: '1, colr: '0, colg: '0};
            img  <= '0;
        end
        else if (!st)
        begin
            scan <= '{row: '1, colr: '0, colg: '0}; // panel dark
            img  <= '0;
        end
        else
        begin
            scan.row  <= row_sel;
            scan.colg <= rom_colg;
            scan.colr <= hot ? rom_colg : '0; // red on top of green gives amber
            img       <= img_idx;
        end
    end

endmodule

// File: design/dz_display_top.sv
`timescale 1ns/1ps

module dz_display_top
    import dz_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic [7:0] temp_code,
    input  logic       cfg_wr,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_wdata,
    output dz_scan_t   scan,
    output dz_img_t    img,
    output logic       hot
);

    dz_cfg_t cfg;
    dz_row_t row_idx;
    dz_img_t img_idx;

    dz_config_regs dz_config_regs_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    dz_frame_seq dz_frame_seq_i (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .cfg     (cfg),
        .row_idx (row_idx),
        .img_idx (img_idx)
    );

    dz_temp_monitor dz_temp_monitor_i (
        .clk       (clk),
        .rst       (rst),
        .temp_code (temp_code),
        .cfg       (cfg),
        .hot       (hot)
    );

    // hot goes out directly and also gates the red plane
    dz_show dz_show_i (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .row_idx (row_idx),
        .img_idx (img_idx),
        .hot     (hot),
        .scan    (scan),
        .img     (img)
    );

endmodule

// File: testbench/tb_dz_patterns.svh
`ifndef TB_DZ_PATTERNS_SVH
`define TB_DZ_PATTERNS_SVH

// one 64 bit picture per image with row 0 in the top byte
function automatic dz_cols_t expected_cols(input dz_img_t i, input dz_row_t r);
    logic [63:0] pic;
    case (i)
        4'd0:    pic = 64'h0000_183c_3c18_0000; // smallest blob
        4'd1:    pic = 64'h0000_387c_7c38_0000;
        4'd2:    pic = 64'h0000_3c7e_7e3c_0000;
        4'd3:    pic = 64'h003c_7e7e_7e7e_3c00;
        4'd4:    pic = 64'h3c7e_ffff_ffff_7e3c;
        4'd5:    pic = 64'hffff_ffff_ffff_ffff; // all lit
        4'd6:    pic = 64'hc3e3_f1e3_c7e7_f7fb;
        4'd7:    pic = 64'h0001_81c3_83c7_e7f3;
        4'd8:    pic = 64'h0038_445a_4a32_c438;
        4'd9:    pic = 64'h0000_60fc_3f3e_1c00;
        4'd10:   pic = 64'h0000_183c_7e7e_2400;
        4'd11:   pic = 64'he060_e030_3133_3e1c;
        default: pic = '0;
    endcase
    return pic[63 - 8 * int'(r) -: 8];
endfunction

`endif

// File: testbench/tb_dz_display.sv
`timescale 1ns/1ps

module tb_dz_display
    import dz_pkg::*;
();

    `include "tb_dz_patterns.svh"

    localparam dz_scan_t blank_scan = '{row: '1, colr: '0, colg: '0};

    logic       clk, rst, st, cfg_wr;
    logic [7:0] temp_code, cfg_wdata;
    logic [1:0] cfg_addr;
    dz_scan_t   scan;
    dz_img_t    img;
    logic       hot;

    // values seen at the previous falling edge
    logic        rst_seen = 1'b1;
    logic        st_seen, hot_seen, wr_seen, was_active;
    logic [1:0]  addr_seen;
    logic [7:0]  temp_seen, wdata_seen;
    dz_cfg_t     cfg_model;
    int          last_idx;
    dz_img_t     last_img;
    logic [31:0] lfsr_state = 32'h7f93;

    dz_display_top dz_display_top_i (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp_code (temp_code),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .scan      (scan),
        .img       (img),
        .hot       (hot)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic expected_hot(input logic [7:0] t, input logic h, input dz_cfg_t c);
        int low;
        low = int'(c.hot_threshold) - int'(c.hysteresis);
        if (low < 0)
            low = 0; // falling level never wraps
        if (t >= c.hot_threshold)
            return 1'b1;
        if (int'(t) < low)
            return 1'b0;
        return h;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_scan(input dz_scan_t got, input dz_scan_t exp);
        if (got !== exp)
            report_mismatch("scan", got, exp);
    endtask

    task automatic check_img(input dz_img_t got, input dz_img_t exp);
        if (got !== exp)
            report_mismatch("img", got, exp);
    endtask

    task automatic check_hot(input logic got, input logic exp);
        if (got !== exp)
            report_mismatch("hot", got, exp);
    endtask

    // compares every cycle against the model
    always @(negedge clk)
    begin : compare_outputs
        dz_scan_t exp_scan;
        dz_cols_t green;
        int       zeros;
        int       idx;
        if (rst || rst_seen)
        begin
            cfg_model = '{frame_period: 8'd4, hot_threshold: 8'd80, hysteresis: 4'd4};
            check_scan(scan, blank_scan);
            check_img(img, '0);
            check_hot(hot, 1'b0);
            was_active = 1'b0;
        end
        else
        begin
            check_hot(hot, expected_hot(temp_seen, hot_seen, cfg_model));
            if (wr_seen)
                case (addr_seen) // lands one cycle after the strobe
                    2'd0:    cfg_model.frame_period = wdata_seen;
                    2'd1:    cfg_model.hot_threshold = wdata_seen;
                    2'd2:    cfg_model.hysteresis = wdata_seen[3:0];
                    default: ;
                endcase
            if (!st_seen)
            begin
                check_scan(scan, blank_scan);
                check_img(img, '0);
                was_active = 1'b0;
            end
            else
            begin
                zeros = 0;
                idx = 0;
                for (int b = 0; b < dz_rows; b++)
                    if (!scan.row[b])
                    begin
                        zeros++;
                        idx = b;
                    end
                if (zeros != 1)
                    stop_run("row select does not have exactly one active row");
                if (idx != (was_active ? (last_idx + 1) % dz_rows : 0))
                    report_mismatch("row index", idx, was_active ? (last_idx + 1) % dz_rows : 0);
                if (!was_active)
                    check_img(img, '0); // restart from image 0
                else if (idx != 0)
                    check_img(img, last_img);
                else if (img != last_img)
                    check_img(img, dz_img_t'((last_img + 1) % dz_num_images));
                green = expected_cols(img, dz_row_t'(idx));
                exp_scan.row  = ~(8'h01 << idx);
                exp_scan.colg = green;
                exp_scan.colr = hot_seen ? green : '0;
                check_scan(scan, exp_scan);
                last_idx = idx;
                last_img = img;
                was_active = 1'b1;
            end
        end
        rst_seen = rst;
        st_seen = st;
        hot_seen = hot;
        temp_seen = temp_code;
        wr_seen = cfg_wr;
        addr_seen = cfg_addr;
        wdata_seen = cfg_wdata;
    end

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    task automatic wait_img_change(input int limit, output int cycles);
        dz_img_t start;
        @(negedge clk);
        start = img;
        cycles = 1;
        while (img == start)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                stop_run("timeout: the image index never changed");
        end
    endtask

    task automatic wait_hot(input logic value, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hot !== value)
        begin
            cycles++;
            if (cycles > limit)
                stop_run($sformatf("timeout: hot never went to %0d", value));
            @(negedge clk);
        end
    endtask

    // first change only resyncs since a period change may shorten it
    task automatic check_intervals(input int span, input int count);
        int n;
        wait_img_change(600, n);
        repeat (count)
        begin
            wait_img_change(600, n);
            if (n != span)
                report_mismatch("image interval", n, span);
        end
    endtask

    task automatic drive_random_temps(input int n);
        repeat (n)
        begin
            @(posedge clk);
            temp_code <= 8'd90 + 8'(lfsr_bits(4)); // 90..105 straddles the band
        end
    endtask

    initial
    begin
        rst       = 1'b1;
        st        = 1'b0;
        temp_code = 8'd0;
        cfg_wr    = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = 8'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(negedge clk);
        check_scan(scan, blank_scan);
        check_img(img, '0);
        check_hot(hot, 1'b0);

        @(posedge clk);
        st <= 1'b1;
        check_intervals(32, 12); // default period 4 over all twelve images
        write_reg(2'd0, 8'd2);
        check_intervals(16, 3);
        write_reg(2'd0, 8'd0);
        check_intervals(8, 3);

        write_reg(2'd1, 8'd100);
        write_reg(2'd2, 8'd5);
        @(posedge clk);
        temp_code <= 8'd120;
        wait_hot(1'b1, 4);
        @(posedge clk);
        temp_code <= 8'd97; // inside the band
        repeat (6) @(negedge clk);
        check_hot(hot, 1'b1);
        @(posedge clk);
        temp_code <= 8'd90;
        wait_hot(1'b0, 4);
        drive_random_temps(300);

        write_reg(2'd3, 8'(lfsr_bits(8)));
        drive_random_temps(100);
        check_intervals(8, 2);

        @(posedge clk);
        st <= 1'b0;
        repeat (2) @(negedge clk);
        check_scan(scan, blank_scan);
        check_img(img, '0);
        @(posedge clk);
        st <= 1'b1;
        check_intervals(8, 2);

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+testbench
design/dz_pkg.sv
design/dz_config_regs.sv
design/dz_frame_seq.sv
design/dz_temp_monitor.sv
design/dz_show.sv
design/dz_display_top.sv
testbench/tb_dz_display.sv

// File: Bender.yml
package:
  name: dz_display

sources:
  - design/dz_pkg.sv
  - design/dz_config_regs.sv
  - design/dz_frame_seq.sv
  - design/dz_temp_monitor.sv
  - design/dz_show.sv
  - design/dz_display_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_dz_display.sv
